/* rtl/exu_pkg.sv */
package exu_pkg;

   localparam int data_w     = 32;
   localparam int reg_addr_w = 5;

   // wait cycles before an unanswered access is abandoned
   localparam int bus_timeout = 16;
   localparam int timer_w     = $clog2(bus_timeout + 1);
   localparam logic [timer_w-1:0] timer_max = bus_timeout[timer_w-1:0];

   typedef enum logic [4:0] {
      op_add, op_sub, op_and, op_or, op_xor,
      op_slt, op_sltu, op_sll, op_srl, op_sra,
      op_beq, op_bne, op_blt, op_bge,
      op_lw, op_lb, op_sw, op_sb
   } op_t;

   typedef enum logic [1:0] {
      st_idle,
      st_mem,  // waiting on the load/store unit
      st_wb
   } ctrl_state_t;

   function automatic logic is_alu_op(op_t op);
      return op inside {op_add, op_sub, op_and, op_or, op_xor,
                        op_slt, op_sltu, op_sll, op_srl, op_sra};
   endfunction

   function automatic logic is_branch_op(op_t op);
      return op inside {op_beq, op_bne, op_blt, op_bge};
   endfunction

   function automatic logic is_mem_op(op_t op);
      return op inside {op_lw, op_lb, op_sw, op_sb};
   endfunction

endpackage

/* rtl/exu_lsu_if.sv */
interface exu_lsu_if;

   // request, one-cycle start
   logic                       start;
   logic                       is_store;
   logic                       is_byte;
   logic [exu_pkg::data_w-1:0] base;
   logic [exu_pkg::data_w-1:0] offset;
   logic [exu_pkg::data_w-1:0] store_data;

   // completion, fault and timed_out qualify done
   logic                       done;
   logic                       fault;
   logic                       timed_out;
   logic [exu_pkg::data_w-1:0] load_data;

   modport ctrl (
      output start, is_store, is_byte, base, offset, store_data,
      input  done, fault, timed_out, load_data
   );

   modport lsu (
      input  start, is_store, is_byte, base, offset, store_data,
      output done, fault, timed_out, load_data
   );

endinterface

/* rtl/exu_regfile.sv */
module exu_regfile (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic [exu_pkg::reg_addr_w-1:0] rs1_addr,
   input  logic [exu_pkg::reg_addr_w-1:0] rs2_addr,
   input  logic [exu_pkg::reg_addr_w-1:0] rd_addr,
   input  logic                           rd_wen,
   input  logic [exu_pkg::data_w-1:0]     rd_data,
   output logic [exu_pkg::data_w-1:0]     rs1_data,
   output logic [exu_pkg::data_w-1:0]     rs2_data
);

   localparam int num_regs = 2 ** exu_pkg::reg_addr_w;

   // r0 has no storage
   logic [exu_pkg::data_w-1:0] regs [1:num_regs-1];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 1; i < num_regs; i++) begin
            regs[i] <= '0;
         end
      end else if (rd_wen && (rd_addr != '0)) begin
         regs[rd_addr] <= rd_data;
      end
   end

   always_comb begin
      rs1_data = '0;
      rs2_data = '0;
      if (rs1_addr != '0) begin
         rs1_data = regs[rs1_addr];
      end
      if (rs2_addr != '0) begin
         rs2_data = regs[rs2_addr];
      end
   end

endmodule

/* rtl/exu_alu.sv */
module exu_alu (
   input  exu_pkg::op_t               op,
   input  logic [exu_pkg::data_w-1:0] a,
   input  logic [exu_pkg::data_w-1:0] b,
   output logic [exu_pkg::data_w-1:0] result
);

   logic [4:0] shamt;
   logic       lt_signed;
   logic       lt_unsigned;

   assign shamt       = b[4:0];
   assign lt_signed   = $signed(a) < $signed(b);
   assign lt_unsigned = a < b;

   always_comb begin
      unique case (op)
         exu_pkg::op_add:  result = a + b;
         exu_pkg::op_sub:  result = a - b;
         exu_pkg::op_and:  result = a & b;
         exu_pkg::op_or:   result = a | b;
         exu_pkg::op_xor:  result = a ^ b;
         exu_pkg::op_slt: begin
            result = {{(exu_pkg::data_w-1){1'b0}}, lt_signed};
         end
         exu_pkg::op_sltu: begin
            result = {{(exu_pkg::data_w-1){1'b0}}, lt_unsigned};
         end
         exu_pkg::op_sll:  result = a << shamt;
         exu_pkg::op_srl:  result = a >> shamt;
         exu_pkg::op_sra:  result = $signed(a) >>> shamt;  // sign fill
         default:          result = '0;  // branch and memory ops
      endcase
   end

endmodule

/* rtl/exu_branch.sv */
module exu_branch (
   input  exu_pkg::op_t               op,
   input  logic [exu_pkg::data_w-1:0] a,
   input  logic [exu_pkg::data_w-1:0] b,
   input  logic [exu_pkg::data_w-1:0] pc,
   input  logic [exu_pkg::data_w-1:0] offset,
   output logic                       taken,
   output logic [exu_pkg::data_w-1:0] target
);

   logic equal;
   logic less;

   assign equal = a == b;
   assign less  = $signed(a) < $signed(b);

   // target does not depend on the outcome
   assign target = pc + offset;

   always_comb begin
      case (op)
         exu_pkg::op_beq: taken = equal;
         exu_pkg::op_bne: taken = !equal;
         exu_pkg::op_blt: taken = less;
         exu_pkg::op_bge: taken = !less;
         default:         taken = 1'b0;
      endcase
   end

endmodule

/* rtl/exu_bus_timer.sv */
module exu_bus_timer (
   input  logic clk,
   input  logic rst_n,
   input  logic enable,
   output logic expired
);

   logic [exu_pkg::timer_w-1:0] count;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         count <= '0;
      end else if (!enable) begin
         count <= '0;
      end else if (count != exu_pkg::timer_max) begin
         count <= count + 1'b1;  // holds at the limit
      end
   end

   assign expired = count == exu_pkg::timer_max;

endmodule

/* rtl/exu_lsu.sv */
module exu_lsu (
   input  logic                       clk,
   input  logic                       rst_n,
   exu_lsu_if.lsu                     lsu,
   input  logic [exu_pkg::data_w-1:0] wb_dat_i,
   input  logic                       wb_ack,
   output logic                       wb_cyc,
   output logic                       wb_stb,
   output logic                       wb_we,
   output logic [exu_pkg::data_w-1:0] wb_adr,
   output logic [exu_pkg::data_w-1:0] wb_dat_o,
   output logic [3:0]                 wb_sel
);

   logic [exu_pkg::data_w-1:0] addr;
   logic                       misalign;
   logic                       fault_q;
   logic                       byte_q;
   logic                       expired;
   logic                       bus_end;
   logic [7:0]                 load_byte;

   assign addr     = lsu.base + lsu.offset;
   assign misalign = !lsu.is_byte && (addr[1:0] != 2'b00);  // words only

   exu_bus_timer u_bus_timer (
      .clk     (clk),
      .rst_n   (rst_n),
      .enable  (wb_cyc),
      .expired (expired)
   );

   assign bus_end = wb_cyc && (wb_ack || expired);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wb_cyc  <= 1'b0;
         wb_stb  <= 1'b0;
         fault_q <= 1'b0;
      end else begin
         fault_q <= lsu.start && misalign;
         if (lsu.start && !misalign) begin
            wb_cyc <= 1'b1;
            wb_stb <= 1'b1;
         end else if (bus_end) begin
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
         end
      end
   end

   // held stable for the whole cycle, start only comes while idle
   always_ff @(posedge clk) begin
      if (lsu.start) begin
         wb_we    <= lsu.is_store;
         wb_adr   <= addr;
         byte_q   <= lsu.is_byte;
         wb_dat_o <= lsu.is_byte ? {4{lsu.store_data[7:0]}} : lsu.store_data;
         wb_sel   <= lsu.is_byte ? (4'b0001 << addr[1:0]) : 4'b1111;
      end
   end

   assign load_byte = wb_dat_i[{wb_adr[1:0], 3'b000} +: 8];

   assign lsu.done      = fault_q || bus_end;
   assign lsu.fault     = fault_q;
   assign lsu.timed_out = wb_cyc && expired && !wb_ack;  // ack wins a tie
   assign lsu.load_data = byte_q ? {{(exu_pkg::data_w-8){1'b0}}, load_byte} : wb_dat_i;

endmodule

/* rtl/exu_ctrl.sv */
module exu_ctrl (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           issue_valid,
   input  exu_pkg::op_t                   issue_op,
   input  logic [exu_pkg::reg_addr_w-1:0] issue_rd,
   input  logic [exu_pkg::data_w-1:0]     issue_imm,
   input  logic                           issue_use_imm,
   input  logic [exu_pkg::data_w-1:0]     issue_pc,
   input  logic [exu_pkg::data_w-1:0]     rs1_data,
   input  logic [exu_pkg::data_w-1:0]     rs2_data,
   input  logic [exu_pkg::data_w-1:0]     alu_result,
   input  logic                           br_taken_c,
   input  logic [exu_pkg::data_w-1:0]     br_target_c,
   exu_lsu_if.ctrl                        lsu,
   output logic                           issue_ready,
   output logic [exu_pkg::data_w-1:0]     alu_b,
   output logic [exu_pkg::reg_addr_w-1:0] rd_addr,
   output logic                           rd_wen,
   output logic [exu_pkg::data_w-1:0]     rd_data,
   output logic                           br_valid,
   output logic                           br_taken,
   output logic [exu_pkg::data_w-1:0]     br_target,
   output logic                           align_error,
   output logic                           bus_error
);

   exu_pkg::ctrl_state_t           state;
   logic                           accept;
   logic                           mem_done;
   logic [exu_pkg::reg_addr_w-1:0] rd_q;
   logic                           is_load_q;
   logic [exu_pkg::data_w-1:0]     load_q;

   assign issue_ready = state == exu_pkg::st_idle;
   assign accept      = issue_valid && issue_ready;
   assign mem_done    = (state == exu_pkg::st_mem) && lsu.done;
   assign alu_b       = issue_use_imm ? issue_imm : rs2_data;

   assign lsu.start      = accept && exu_pkg::is_mem_op(issue_op);
   assign lsu.is_store   = issue_op inside {exu_pkg::op_sw, exu_pkg::op_sb};
   assign lsu.is_byte    = issue_op inside {exu_pkg::op_lb, exu_pkg::op_sb};
   assign lsu.base       = rs1_data;
   assign lsu.offset     = issue_imm;
   assign lsu.store_data = rs2_data;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state       <= exu_pkg::st_idle;
         br_valid    <= 1'b0;
         br_taken    <= 1'b0;
         align_error <= 1'b0;
         bus_error   <= 1'b0;
      end else begin
         br_valid    <= accept && exu_pkg::is_branch_op(issue_op);
         br_taken    <= accept && exu_pkg::is_branch_op(issue_op) && br_taken_c;
         align_error <= mem_done && lsu.fault;  // high during wb
         bus_error   <= mem_done && lsu.timed_out;
         case (state)
            exu_pkg::st_idle: if (lsu.start) state <= exu_pkg::st_mem;
            exu_pkg::st_mem:  if (lsu.done) state <= exu_pkg::st_wb;
            default:          state <= exu_pkg::st_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (lsu.start) begin
         rd_q      <= issue_rd;
         is_load_q <= !lsu.is_store;
      end
      if (mem_done) begin
         load_q <= lsu.load_data;
      end
      if (accept && exu_pkg::is_branch_op(issue_op)) begin
         br_target <= br_target_c;
      end
   end

   // alu results go straight in, loads wait for wb
   always_comb begin
      if (state == exu_pkg::st_wb) begin
         rd_addr = rd_q;
         rd_data = load_q;
         rd_wen  = is_load_q && !align_error && !bus_error;
      end else begin
         rd_addr = issue_rd;
         rd_data = alu_result;
         rd_wen  = accept && exu_pkg::is_alu_op(issue_op);
      end
   end

endmodule

/* rtl/exu_top.sv */
module exu_top (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           issue_valid,
   input  exu_pkg::op_t                   issue_op,
   input  logic [exu_pkg::reg_addr_w-1:0] issue_rd,
   input  logic [exu_pkg::reg_addr_w-1:0] issue_rs1,
   input  logic [exu_pkg::reg_addr_w-1:0] issue_rs2,
   input  logic [exu_pkg::data_w-1:0]     issue_imm,
   input  logic                           issue_use_imm,
   input  logic [exu_pkg::data_w-1:0]     issue_pc,
   output logic                           issue_ready,
   output logic                           br_valid,
   output logic                           br_taken,
   output logic [exu_pkg::data_w-1:0]     br_target,
   output logic                           wb_cyc,
   output logic                           wb_stb,
   output logic                           wb_we,
   output logic [exu_pkg::data_w-1:0]     wb_adr,
   output logic [exu_pkg::data_w-1:0]     wb_dat_o,
   output logic [3:0]                     wb_sel,
   input  logic [exu_pkg::data_w-1:0]     wb_dat_i,
   input  logic                           wb_ack,
   output logic                           align_error,
   output logic                           bus_error
);

   logic [exu_pkg::data_w-1:0]     rs1_data;
   logic [exu_pkg::data_w-1:0]     rs2_data;
   logic [exu_pkg::data_w-1:0]     alu_b;
   logic [exu_pkg::data_w-1:0]     alu_result;
   logic                           br_taken_c;
   logic [exu_pkg::data_w-1:0]     br_target_c;
   logic [exu_pkg::reg_addr_w-1:0] rd_addr;
   logic                           rd_wen;
   logic [exu_pkg::data_w-1:0]     rd_data;

   exu_lsu_if lsu_bus ();

   exu_ctrl u_ctrl (
      .clk           (clk),
      .rst_n         (rst_n),
      .issue_valid   (issue_valid),
      .issue_op      (issue_op),
      .issue_rd      (issue_rd),
      .issue_imm     (issue_imm),
      .issue_use_imm (issue_use_imm),
      .issue_pc      (issue_pc),
      .rs1_data      (rs1_data),
      .rs2_data      (rs2_data),
      .alu_result    (alu_result),
      .br_taken_c    (br_taken_c),
      .br_target_c   (br_target_c),
      .lsu           (lsu_bus.ctrl),
      .issue_ready   (issue_ready),
      .alu_b         (alu_b),
      .rd_addr       (rd_addr),
      .rd_wen        (rd_wen),
      .rd_data       (rd_data),
      .br_valid      (br_valid),
      .br_taken      (br_taken),
      .br_target     (br_target),
      .align_error   (align_error),
      .bus_error     (bus_error)
   );

   exu_regfile u_regfile (
      .clk      (clk),
      .rst_n    (rst_n),
      .rs1_addr (issue_rs1),
      .rs2_addr (issue_rs2),
      .rd_addr  (rd_addr),
      .rd_wen   (rd_wen),
      .rd_data  (rd_data),
      .rs1_data (rs1_data),
      .rs2_data (rs2_data)
   );

   exu_alu u_alu (
      .op     (issue_op),
      .a      (rs1_data),
      .b      (alu_b),
      .result (alu_result)
   );

   exu_branch u_branch (
      .op     (issue_op),
      .a      (rs1_data),
      .b      (rs2_data),
      .pc     (issue_pc),
      .offset (issue_imm),
      .taken  (br_taken_c),
      .target (br_target_c)
   );

   exu_lsu u_lsu (
      .clk      (clk),
      .rst_n    (rst_n),
      .lsu      (lsu_bus.lsu),
      .wb_dat_i (wb_dat_i),
      .wb_ack   (wb_ack),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_o (wb_dat_o),
      .wb_sel   (wb_sel)
   );

endmodule

/* tb/exu_wb_mem.sv */
module exu_wb_mem #(
   parameter logic [31:0] dead_base = 32'h0000_1000  // no ack at or above
) (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        cyc,
   input  logic        stb,
   input  logic        we,
   input  logic [31:0] adr,
   input  logic [31:0] dat_w,
   input  logic [3:0]  sel,
   output logic [31:0] dat_r,
   output logic        ack
);
   timeunit 1ns;
   timeprecision 1ps;

   localparam int depth       = 256;
   localparam int wait_cycles = 2;

   logic [31:0] mem [0:depth-1];
   logic [31:0] merged;
   logic [7:0]  idx;
   int          cnt;

   initial begin
      for (int i = 0; i < depth; i++) begin
         mem[i] = (32'(i) * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
      end
   end

   assign idx = adr[9:2];

   always_comb begin
      for (int b = 0; b < 4; b++) begin
         merged[b*8 +: 8] = sel[b] ? dat_w[b*8 +: 8] : mem[idx][b*8 +: 8];
      end
   end

   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ack   <= 1'b0;
         cnt   <= 0;
         dat_r <= '0;
      end else if (ack) begin
         ack <= 1'b0;
         cnt <= 0;
      end else if (cyc && stb && (adr < dead_base)) begin
         if (cnt == wait_cycles) begin
            ack   <= 1'b1;
            dat_r <= mem[idx];
            if (we) mem[idx] <= merged;
         end else begin
            cnt <= cnt + 1;
         end
      end
   end

endmodule

/* tb/exu_tb.sv */
module exu_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int          max_instr    = 200;
   localparam int          worst_cycles = exu_pkg::bus_timeout + 8;
   localparam logic [31:0] dead_base    = 32'h0000_1000;

   logic         clk = 1'b0;
   logic         rst_n;
   logic         issue_valid;
   exu_pkg::op_t issue_op;
   logic [4:0]   issue_rd, issue_rs1, issue_rs2;
   logic [31:0]  issue_imm, issue_pc;
   logic         issue_use_imm;
   logic         issue_ready;
   logic         br_valid, br_taken;
   logic [31:0]  br_target;
   logic         wb_cyc, wb_stb, wb_we, wb_ack;
   logic [31:0]  wb_adr, wb_dat_o, wb_dat_i;
   logic [3:0]   wb_sel;
   logic         align_error, bus_error;

   integer      seed = 5;
   logic [31:0] sh [0:31];  // expected register file
   int          issued = 0;
   int          accepted = 0;
   logic        br_accept;

   always #2 clk = ~clk;

   exu_top DUT (.*);

   exu_wb_mem #(.dead_base(dead_base)) u_mem (
      .clk   (clk),
      .rst_n (rst_n),
      .cyc   (wb_cyc),
      .stb   (wb_stb),
      .we    (wb_we),
      .adr   (wb_adr),
      .dat_w (wb_dat_o),
      .sel   (wb_sel),
      .dat_r (wb_dat_i),
      .ack   (wb_ack)
   );

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("SOME TESTS FAILED");
      $fatal(1);
   endtask

   function automatic logic [31:0] alu_model(exu_pkg::op_t op, logic [31:0] a, logic [31:0] b);
      case (op)
         exu_pkg::op_add:  return a + b;
         exu_pkg::op_sub:  return a - b;
         exu_pkg::op_and:  return a & b;
         exu_pkg::op_or:   return a | b;
         exu_pkg::op_xor:  return a ^ b;
         exu_pkg::op_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         exu_pkg::op_sltu: return (a < b) ? 32'd1 : 32'd0;
         exu_pkg::op_sll:  return a << b[4:0];
         exu_pkg::op_srl:  return a >> b[4:0];
         exu_pkg::op_sra:  return $signed(a) >>> b[4:0];
         default:          return 32'd0;
      endcase
   endfunction

   function automatic logic branch_model(exu_pkg::op_t op, logic [31:0] a, logic [31:0] b);
      case (op)
         exu_pkg::op_beq: return a == b;
         exu_pkg::op_bne: return a != b;
         exu_pkg::op_blt: return $signed(a) < $signed(b);
         default:         return $signed(a) >= $signed(b);
      endcase
   endfunction

   assign br_accept = issue_valid && issue_ready &&
                      (issue_op inside {exu_pkg::op_beq, exu_pkg::op_bne,
                                        exu_pkg::op_blt, exu_pkg::op_bge});

   always @(posedge clk) begin
      if (rst_n && issue_valid && issue_ready) accepted++;
   end

   assert property (@(posedge clk) disable iff (!rst_n) wb_cyc == wb_stb)
      else report_failure($sformatf("FAIL wb_stb got %h expected %h", wb_stb, wb_cyc));

   // request held steady until ack or a timeout with bus_error
   assert property (@(posedge clk) disable iff (!rst_n)
      (wb_cyc && !wb_ack) |=> ((wb_cyc && $stable(wb_adr) && $stable(wb_dat_o) &&
                                $stable(wb_we) && $stable(wb_sel)) ||
                               (!wb_cyc && bus_error)))
      else report_failure("Wishbone request changed or ended before ack");

   assert property (@(posedge clk) disable iff (!rst_n) br_valid == $past(br_accept))
      else report_failure($sformatf("FAIL br_valid got %h expected %h", br_valid, !br_valid));

   // random issue inputs while the DUT is busy
   task automatic drive_garbage();
      logic [31:0] r;
      logic [4:0]  k;
      r = $random(seed);
      k = r[4:0];
      if (k > 5'd17) k = k - 5'd14;
      issue_valid   = 1'b1;
      issue_op      = exu_pkg::op_t'(k);
      issue_rd      = r[9:5];
      issue_rs1     = r[14:10];
      issue_rs2     = r[19:15];
      issue_use_imm = r[20];
      issue_imm     = $random(seed);
      issue_pc      = $random(seed);
   endtask

   task automatic watch_mem(input exu_pkg::op_t op, input logic [4:0] rd,
                            input logic [31:0] addr, input logic [31:0] data);
      logic        is_byte, is_store, misaligned, dead;
      logic        saw_cyc, saw_align, saw_bus;
      int          cyc_cycles;
      logic [31:0] load_word, exp_dat;
      logic [3:0]  exp_sel;
      is_byte    = op inside {exu_pkg::op_lb, exu_pkg::op_sb};
      is_store   = op inside {exu_pkg::op_sw, exu_pkg::op_sb};
      misaligned = !is_byte && (addr[1:0] != 2'b00);
      dead       = addr >= dead_base;
      load_word  = u_mem.mem[addr[9:2]];
      exp_sel    = is_byte ? (4'b0001 << addr[1:0]) : 4'b1111;
      exp_dat    = is_byte ? {4{data[7:0]}} : data;
      saw_cyc    = 1'b0;
      saw_align  = 1'b0;
      saw_bus    = 1'b0;
      cyc_cycles = 0;
      while (!issue_ready) begin
         if (wb_cyc) begin
            saw_cyc = 1'b1;
            cyc_cycles++;
            assert (wb_adr == addr)
               else report_failure($sformatf("FAIL wb_adr got %h expected %h", wb_adr, addr));
            assert (wb_we == is_store)
               else report_failure($sformatf("FAIL wb_we got %h expected %h", wb_we, is_store));
            if (is_store) begin
               assert (wb_sel == exp_sel)
                  else report_failure($sformatf("FAIL wb_sel got %h expected %h",
                                                wb_sel, exp_sel));
               assert (wb_dat_o == exp_dat)
                  else report_failure($sformatf("FAIL wb_dat_o got %h expected %h",
                                                wb_dat_o, exp_dat));
            end
         end
         if (align_error) saw_align = 1'b1;
         if (bus_error) saw_bus = 1'b1;
         drive_garbage();
         @(posedge clk);
         #1;
      end
      issue_valid = 1'b0;
      if (misaligned) begin
         assert (saw_align && !saw_cyc && !saw_bus)
            else report_failure("misaligned access missed align_error or started a bus cycle");
      end else if (dead) begin
         assert (saw_bus && !saw_align && cyc_cycles == exu_pkg::bus_timeout + 1)
            else report_failure("unanswered access did not time out as expected");
      end else begin
         assert (saw_cyc && !saw_align && !saw_bus)
            else report_failure("aligned access did not complete a clean bus cycle");
         if (!is_store && rd != 5'd0) begin
            sh[rd] = is_byte ? {24'd0, load_word[{addr[1:0], 3'b000} +: 8]} : load_word;
         end
      end
   endtask

   // called 1 ns after a rising edge
   task automatic issue(input exu_pkg::op_t op, input logic [4:0] rd, input logic [4:0] rs1,
                        input logic [4:0] rs2, input logic [31:0] imm, input logic use_imm);
      logic [31:0] pc, a, b, exp_alu;
      logic        exp_taken;
      while (!issue_ready) begin
         drive_garbage();
         @(posedge clk);
         #1;
      end
      pc            = $random(seed);
      a             = sh[rs1];
      b             = sh[rs2];
      exp_alu       = alu_model(op, a, use_imm ? imm : b);
      exp_taken     = branch_model(op, a, b);
      issue_valid   = 1'b1;
      issue_op      = op;
      issue_rd      = rd;
      issue_rs1     = rs1;
      issue_rs2     = rs2;
      issue_imm     = imm;
      issue_use_imm = use_imm;
      issue_pc      = pc;
      @(posedge clk);
      #1;
      issue_valid = 1'b0;
      issued++;
      if (exu_pkg::is_alu_op(op)) begin
         if (rd != 5'd0) sh[rd] = exp_alu;
      end else if (exu_pkg::is_branch_op(op)) begin
         assert (br_taken == exp_taken)
            else report_failure($sformatf("FAIL br_taken got %h expected %h",
                                          br_taken, exp_taken));
         assert (br_target == pc + imm)
            else report_failure($sformatf("FAIL br_target got %h expected %h",
                                          br_target, pc + imm));
      end else begin
         watch_mem(op, rd, a + imm, b);
      end
   endtask

   initial begin
      #(max_instr * worst_cycles * 4);
      report_failure("simulation timed out waiting for the DUT");
   end

   initial begin
      logic [31:0] r;
      logic [3:0]  k;
      logic [4:0]  rd;
      for (int i = 0; i < 32; i++) sh[i] = '0;
      rst_n         = 1'b0;
      issue_valid   = 1'b0;
      issue_op      = exu_pkg::op_add;
      issue_rd      = '0;
      issue_rs1     = '0;
      issue_rs2     = '0;
      issue_imm     = '0;
      issue_use_imm = 1'b0;
      issue_pc      = '0;
      repeat (10) @(posedge clk);
      #1 rst_n = 1'b1;
      assert (issue_ready && !wb_cyc && !wb_stb && !br_valid && !align_error && !bus_error)
         else report_failure("outputs not in their reset state after reset");

      for (int i = 1; i < 32; i++) begin
         issue(exu_pkg::op_add, 5'(i), 5'd0, 5'd0, $random(seed), 1'b1);
      end

      // alu op then a store of its result
      for (int i = 0; i < 40; i++) begin
         r  = $random(seed);
         k  = r[3:0];
         if (k > 4'd9) k = k - 4'd6;
         rd = (i == 0) ? 5'd0 : r[8:4];
         issue(exu_pkg::op_t'({1'b0, k}), rd, r[13:9], r[18:14], $random(seed), r[19]);
         issue(exu_pkg::op_sw, 5'd0, 5'd0, rd, 32'h100 + 32'(i * 4), 1'b0);
      end

      for (int i = 0; i < 12; i++) begin
         r = $random(seed);
         issue(exu_pkg::op_t'(5'd10 + {3'd0, r[1:0]}), 5'd0, r[6:2], r[11:7],
               $random(seed), 1'b0);
      end
      // equal operands take beq and bge
      issue(exu_pkg::op_beq, 5'd0, 5'd3, 5'd3, $random(seed), 1'b0);
      issue(exu_pkg::op_bge, 5'd0, 5'd3, 5'd3, $random(seed), 1'b0);

      issue(exu_pkg::op_sw, 5'd0, 5'd0, 5'd7, 32'h200, 1'b0);
      for (int i = 0; i < 4; i++) begin
         issue(exu_pkg::op_sb, 5'd0, 5'd0, 5'(8 + i), 32'h204 + 32'(i), 1'b0);
      end
      issue(exu_pkg::op_lw, 5'd12, 5'd0, 5'd0, 32'h204, 1'b0);
      issue(exu_pkg::op_sw, 5'd0, 5'd0, 5'd12, 32'h208, 1'b0);
      issue(exu_pkg::op_lb, 5'd13, 5'd0, 5'd0, 32'h206, 1'b0);
      issue(exu_pkg::op_sw, 5'd0, 5'd0, 5'd13, 32'h20c, 1'b0);
      issue(exu_pkg::op_lb, 5'd14, 5'd0, 5'd0, 32'h201, 1'b0);
      issue(exu_pkg::op_sw, 5'd0, 5'd0, 5'd14, 32'h210, 1'b0);

      issue(exu_pkg::op_lw, 5'd5, 5'd0, 5'd0, 32'h102, 1'b0);
      issue(exu_pkg::op_sw, 5'd0, 5'd0, 5'd5, 32'h301, 1'b0);
      issue(exu_pkg::op_sw, 5'd0, 5'd0, 5'd5, 32'h110, 1'b0);

      issue(exu_pkg::op_lw, 5'd6, 5'd0, 5'd0, dead_base, 1'b0);
      issue(exu_pkg::op_sw, 5'd0, 5'd0, 5'd6, dead_base + 32'h4, 1'b0);
      issue(exu_pkg::op_sw, 5'd0, 5'd0, 5'd6, 32'h114, 1'b0);

      if (accepted == issued) begin
         $display("ALL TESTS PASSED");
         $finish;
      end else begin
         report_failure($sformatf("DUT accepted %0d instructions but %0d were issued",
                                  accepted, issued));
      end
   end

endmodule

/* flist.f */
rtl/exu_pkg.sv
rtl/exu_lsu_if.sv
rtl/exu_regfile.sv
rtl/exu_alu.sv
rtl/exu_branch.sv
rtl/exu_bus_timer.sv
rtl/exu_lsu.sv
rtl/exu_ctrl.sv
rtl/exu_top.sv
tb/exu_wb_mem.sv
tb/exu_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module exu_tb -f flist.f -o exu_sim

./obj_dir/exu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
   exit 0
else
   exit 1
fi
